//--- common/rv_exec_config.svh
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// data and address width
`define EXEC_XLEN 32

// instruction word width
`define EXEC_ILEN 32

`define EXEC_RESET_PC 32'h0000_0000 // redirect pc out of reset

`endif

//--- common/rv_exec_pkg.sv
package rv_exec_pkg;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI,
        AUIPC,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR
    } alu_op_t;

    typedef enum logic {
        OP2_REG, // rs2
        OP2_IMM  // decoded immediate
    } op2_src_t;

    // major opcodes, low two bits included
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

endpackage

//--- alu/alu.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module alu
    import rv_exec_pkg::*;
(
    input  logic [`EXEC_XLEN-1:0] op1,
    input  logic [`EXEC_XLEN-1:0] op2,
    input  logic [`EXEC_XLEN-1:0] addr,
    input  alu_op_t               alu_op,
    output logic [`EXEC_XLEN-1:0] result,
    output logic                  overflow
);

    logic [4:0]            shamt;
    logic                  lt_s;
    logic                  lt_u;
    logic                  eq;
    logic [`EXEC_XLEN-1:0] sum;
    logic [`EXEC_XLEN-1:0] diff;
    logic [`EXEC_XLEN-1:0] pc_sum;
    logic [`EXEC_XLEN-1:0] link;

    assign shamt  = op2[4:0]; // rv32i uses 5 bits only
    assign lt_s   = $signed(op1) < $signed(op2);
    assign lt_u   = op1 < op2;
    assign eq     = op1 == op2;
    assign sum    = op1 + op2;
    assign diff   = op1 - op2;
    assign pc_sum = addr + op2;
    assign link   = addr + `EXEC_XLEN'(4);

    always_comb
    begin
        result   = '0;
        overflow = 1'b0;

        case (alu_op)
            ADD:
            begin
                result   = sum;
                overflow = (op1[31] == op2[31]) && (sum[31] != op1[31]);
            end
            SUB:
            begin
                result   = diff;
                overflow = (op1[31] != op2[31]) && (diff[31] != op1[31]);
            end
            AUIPC:
            begin
                result   = pc_sum;
                overflow = (addr[31] == op2[31]) && (pc_sum[31] != addr[31]);
            end
            AND:
                result = op1 & op2;
            OR:
                result = op1 | op2;
            XOR:
                result = op1 ^ op2;
            SLL:
                result = op1 << shamt;
            SRL:
                result = op1 >> shamt;
            SRA:
                result = $signed(op1) >>> shamt;
            SLT:
                result = {31'b0, lt_s};
            SLTU:
                result = {31'b0, lt_u};
            LUI:
                result = op2; // u-immediate already shifted
            BEQ:
                result = {31'b0, eq};
            BNE:
                result = {31'b0, ~eq};
            BLT:
                result = {31'b0, lt_s};
            BGE:
                result = {31'b0, ~lt_s};
            BLTU:
                result = {31'b0, lt_u};
            BGEU:
                result = {31'b0, ~lt_u};
            JAL, JALR:
                result = link; // return address
            default:
            begin
                result   = '0;
                overflow = 1'b0;
            end
        endcase
    end

endmodule

//--- hdl/inst_decoder.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module inst_decoder
    import rv_exec_pkg::*;
(
    input  logic [`EXEC_ILEN-1:0] instr,
    output alu_op_t               alu_op,
    output op2_src_t              op2_src,
    output logic [`EXEC_XLEN-1:0] imm,
    output logic [4:0]            rd_addr,
    output logic                  rd_we,
    output logic                  is_branch,
    output logic                  is_jump,
    output logic                  is_jalr,
    output logic                  illegal
);

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [`EXEC_XLEN-1:0] imm_i;
    logic [`EXEC_XLEN-1:0] imm_b;
    logic [`EXEC_XLEN-1:0] imm_u;
    logic [`EXEC_XLEN-1:0] imm_j;

    assign opcode  = instr[6:0];
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rd_addr = instr[11:7];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb
    begin
        alu_op    = ADD;
        op2_src   = OP2_REG;
        imm       = '0;
        rd_we     = 1'b0;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_jalr   = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            OPC_OP:
            begin
                rd_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: alu_op = ADD;
                    10'b0100000_000: alu_op = SUB;
                    10'b0000000_001: alu_op = SLL;
                    10'b0000000_010: alu_op = SLT;
                    10'b0000000_011: alu_op = SLTU;
                    10'b0000000_100: alu_op = XOR;
                    10'b0000000_101: alu_op = SRL;
                    10'b0100000_101: alu_op = SRA;
                    10'b0000000_110: alu_op = OR;
                    10'b0000000_111: alu_op = AND;
                    default:         illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM:
            begin
                rd_we   = 1'b1;
                op2_src = OP2_IMM;
                imm     = imm_i;
                case (funct3)
                    3'b000: alu_op = ADD;
                    3'b010: alu_op = SLT;
                    3'b011: alu_op = SLTU;
                    3'b100: alu_op = XOR;
                    3'b110: alu_op = OR;
                    3'b111: alu_op = AND;
                    3'b001:
                    begin
                        alu_op  = SLL;
                        illegal = (funct7 != 7'b0000000);
                    end
                    default: // 3'b101, srli or srai
                    begin
                        alu_op  = funct7[5] ? SRA : SRL;
                        illegal = ({funct7[6], funct7[4:0]} != 6'b0);
                    end
                endcase
            end
            OPC_LUI:
            begin
                alu_op  = LUI;
                op2_src = OP2_IMM;
                imm     = imm_u;
                rd_we   = 1'b1;
            end
            OPC_AUIPC:
            begin
                alu_op  = AUIPC;
                op2_src = OP2_IMM;
                imm     = imm_u;
                rd_we   = 1'b1;
            end
            OPC_BRANCH:
            begin
                imm       = imm_b;
                is_branch = 1'b1;
                case (funct3)
                    3'b000:  alu_op = BEQ;
                    3'b001:  alu_op = BNE;
                    3'b100:  alu_op = BLT;
                    3'b101:  alu_op = BGE;
                    3'b110:  alu_op = BLTU;
                    3'b111:  alu_op = BGEU;
                    default: illegal = 1'b1;
                endcase
            end
            OPC_JAL:
            begin
                alu_op  = JAL;
                imm     = imm_j;
                rd_we   = 1'b1;
                is_jump = 1'b1;
            end
            OPC_JALR:
            begin
                alu_op  = JALR;
                op2_src = OP2_IMM;
                imm     = imm_i;
                rd_we   = 1'b1;
                is_jump = 1'b1;
                is_jalr = 1'b1;
                illegal = (funct3 != 3'b000);
            end
            default: illegal = 1'b1; // loads, stores, fence, system
        endcase

        if (illegal)
        begin
            rd_we     = 1'b0;
            is_branch = 1'b0;
            is_jump   = 1'b0;
            is_jalr   = 1'b0;
        end
        if (rd_addr == 5'd0)
            rd_we = 1'b0; // x0 stays zero
    end

endmodule

//--- hdl/result_unit.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module result_unit (
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  valid,
    input  logic [`EXEC_XLEN-1:0] pc,
    input  logic [`EXEC_XLEN-1:0] rs1_data,
    input  logic [`EXEC_XLEN-1:0] imm,
    input  logic [`EXEC_XLEN-1:0] alu_result,
    input  logic                  overflow,
    input  logic [4:0]            rd_addr,
    input  logic                  rd_we,
    input  logic                  is_branch,
    input  logic                  is_jump,
    input  logic                  is_jalr,
    input  logic                  illegal,
    output logic                  out_valid,
    output logic                  out_rd_we,
    output logic [4:0]            out_rd_addr,
    output logic [`EXEC_XLEN-1:0] out_rd_data,
    output logic                  out_redirect,
    output logic [`EXEC_XLEN-1:0] out_redirect_pc,
    output logic                  out_overflow,
    output logic                  out_illegal
);

    logic [`EXEC_XLEN-1:0] pc_target;
    logic [`EXEC_XLEN-1:0] jalr_sum;
    logic [`EXEC_XLEN-1:0] target;
    logic                  take;

    assign pc_target = pc + imm; // branches and jal
    assign jalr_sum  = rs1_data + imm;
    assign target    = is_jalr ? {jalr_sum[`EXEC_XLEN-1:1], 1'b0} : pc_target;
    assign take      = is_jump | (is_branch & alu_result[0]);

    always_ff @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
        begin
            out_valid       <= 1'b0;
            out_rd_we       <= 1'b0;
            out_rd_addr     <= '0;
            out_rd_data     <= '0;
            out_redirect    <= 1'b0;
            out_redirect_pc <= `EXEC_RESET_PC;
            out_overflow    <= 1'b0;
            out_illegal     <= 1'b0;
        end
        else
        begin
            out_valid    <= valid;
            out_rd_we    <= valid & rd_we;
            out_rd_addr  <= rd_addr;
            out_rd_data  <= is_branch ? '0 : alu_result;
            out_redirect <= valid & take;
            out_overflow <= valid & overflow & ~illegal;
            out_illegal  <= valid & illegal;
            if (valid && take)
                out_redirect_pc <= target; // holds last target otherwise
        end
    end

endmodule

//--- hdl/exec_stage_top.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module exec_stage_top
    import rv_exec_pkg::*;
(
    input  logic                  clk_in,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  logic [`EXEC_ILEN-1:0] in_instr,
    input  logic [`EXEC_XLEN-1:0] in_pc,
    input  logic [`EXEC_XLEN-1:0] rs1_data,
    input  logic [`EXEC_XLEN-1:0] rs2_data,
    output logic                  out_valid,
    output logic                  out_rd_we,
    output logic [4:0]            out_rd_addr,
    output logic [`EXEC_XLEN-1:0] out_rd_data,
    output logic                  out_redirect,
    output logic [`EXEC_XLEN-1:0] out_redirect_pc,
    output logic                  out_overflow,
    output logic                  out_illegal
);

    alu_op_t               alu_op;
    op2_src_t              op2_src;
    logic [`EXEC_XLEN-1:0] imm;
    logic [4:0]            rd_addr;
    logic                  rd_we;
    logic                  is_branch;
    logic                  is_jump;
    logic                  is_jalr;
    logic                  illegal;
    logic [`EXEC_XLEN-1:0] alu_op2;
    logic [`EXEC_XLEN-1:0] alu_result;
    logic                  overflow;

    inst_decoder u_decoder (
        .instr     (in_instr),
        .alu_op    (alu_op),
        .op2_src   (op2_src),
        .imm       (imm),
        .rd_addr   (rd_addr),
        .rd_we     (rd_we),
        .is_branch (is_branch),
        .is_jump   (is_jump),
        .is_jalr   (is_jalr),
        .illegal   (illegal)
    );

    assign alu_op2 = (op2_src == OP2_IMM) ? imm : rs2_data; // second operand

    alu u_alu (
        .op1      (rs1_data),
        .op2      (alu_op2),
        .addr     (in_pc),
        .alu_op   (alu_op),
        .result   (alu_result),
        .overflow (overflow)
    );

    result_unit u_result (
        .clk_in          (clk_in),
        .rst_n           (rst_n),
        .valid           (in_valid),
        .pc              (in_pc),
        .rs1_data        (rs1_data),
        .imm             (imm),
        .alu_result      (alu_result),
        .overflow        (overflow),
        .rd_addr         (rd_addr),
        .rd_we           (rd_we),
        .is_branch       (is_branch),
        .is_jump         (is_jump),
        .is_jalr         (is_jalr),
        .illegal         (illegal),
        .out_valid       (out_valid),
        .out_rd_we       (out_rd_we),
        .out_rd_addr     (out_rd_addr),
        .out_rd_data     (out_rd_data),
        .out_redirect    (out_redirect),
        .out_redirect_pc (out_redirect_pc),
        .out_overflow    (out_overflow),
        .out_illegal     (out_illegal)
    );

endmodule

//--- bench/exec_stage_tb.sv
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module exec_stage_tb
    import rv_exec_pkg::*;
();

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic        rd_we;
        logic [4:0]  rd_addr;
        logic [31:0] rd_data;
        logic        redirect;
        logic [31:0] redirect_pc;
        logic        overflow;
        logic        illegal;
        logic [15:0] line_no;
    } trace_entry_t;

    logic        clk_in = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        out_valid;
    logic        out_rd_we;
    logic [4:0]  out_rd_addr;
    logic [31:0] out_rd_data;
    logic        out_redirect;
    logic [31:0] out_redirect_pc;
    logic        out_overflow;
    logic        out_illegal;

    trace_entry_t trace_q[$];
    trace_entry_t pending_q[$];
    trace_entry_t expected;
    logic         valid_d;
    logic         trace_loaded = 1'b0;
    int           checked = 0;
    int           cur_line = 0;
    logic [31:0]  cur_instr = '0;

    exec_stage_top u_exec_stage_top (
        .clk_in          (clk_in),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_instr        (in_instr),
        .in_pc           (in_pc),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .out_valid       (out_valid),
        .out_rd_we       (out_rd_we),
        .out_rd_addr     (out_rd_addr),
        .out_rd_data     (out_rd_data),
        .out_redirect    (out_redirect),
        .out_redirect_pc (out_redirect_pc),
        .out_overflow    (out_overflow),
        .out_illegal     (out_illegal)
    );

    always #4 clk_in = ~clk_in; // 8 ns period

    function automatic string opcode_name(input logic [31:0] instr);
        case (instr[6:0])
            OPC_OP:     return "register";
            OPC_OP_IMM: return "immediate";
            OPC_LUI:    return "lui";
            OPC_AUIPC:  return "auipc";
            OPC_BRANCH: return "branch";
            OPC_JAL:    return "jal";
            OPC_JALR:   return "jalr";
            default:    return "non-execute";
        endcase
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        assert (got === exp)
        else
        begin
            $display("Mismatch %s exp=%h got=%h", name, exp, got);
            $display("at trace line %0d, %s instruction %h", cur_line,
                     opcode_name(cur_instr), cur_instr);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic load_trace();
        int           fd;
        int           n;
        int           line_no;
        string        line;
        logic [31:0]  f[11];
        trace_entry_t e;

        line_no = 0;
        fd = $fopen("bench/exec_trace.txt", "r");
        if (fd == 0)
        begin
            $display("error: cannot open bench/exec_trace.txt");
            $display("** FAIL **");
            $fatal(1);
        end
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n > 0 && line.len() > 1 && line[0] != "/") // skip comments and blanks
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                            f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                if (n != 11)
                begin
                    $display("error: trace line %0d does not hold 11 fields", line_no);
                    $display("** FAIL **");
                    $fatal(1);
                end
                e.instr       = f[0];
                e.pc          = f[1];
                e.rs1         = f[2];
                e.rs2         = f[3];
                e.rd_we       = f[4][0];
                e.rd_addr     = f[5][4:0];
                e.rd_data     = f[6];
                e.redirect    = f[7][0];
                e.redirect_pc = f[8];
                e.overflow    = f[9][0];
                e.illegal     = f[10][0];
                e.line_no     = 16'(line_no);
                trace_q.push_back(e);
            end
        end
        $fclose(fd);
        if (trace_q.size() == 0)
        begin
            $display("error: trace file holds no instructions");
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    always @(posedge clk_in or negedge rst_n)
    begin
        if (!rst_n)
            valid_d <= 1'b0;
        else
            valid_d <= in_valid; // what out_valid must show next cycle
    end

    // outputs are sampled mid-cycle
    always @(negedge clk_in)
    begin
        compare_field("out_valid", 32'(valid_d), 32'(out_valid));
        if (out_valid)
        begin
            if (pending_q.size() == 0)
            begin
                $display("error: out_valid high with no instruction pending");
                $display("** FAIL **");
                $fatal(1);
            end
            expected  = pending_q.pop_front();
            cur_line  = int'(expected.line_no);
            cur_instr = expected.instr;
            compare_field("out_rd_we", 32'(expected.rd_we), 32'(out_rd_we));
            compare_field("out_illegal", 32'(expected.illegal), 32'(out_illegal));
            compare_field("out_redirect", 32'(expected.redirect), 32'(out_redirect));
            compare_field("out_overflow", 32'(expected.overflow), 32'(out_overflow));
            if (expected.rd_we)
                compare_field("out_rd_addr", 32'(expected.rd_addr), 32'(out_rd_addr));
            if (expected.rd_we || (expected.instr[6:0] == OPC_BRANCH && !expected.illegal))
                compare_field("out_rd_data", expected.rd_data, out_rd_data);
            if (expected.redirect)
                compare_field("out_redirect_pc", expected.redirect_pc, out_redirect_pc);
            checked++;
        end
        else
        begin
            compare_field("out_rd_we", 32'h0, 32'(out_rd_we));
            compare_field("out_redirect", 32'h0, 32'(out_redirect));
            compare_field("out_overflow", 32'h0, 32'(out_overflow));
            compare_field("out_illegal", 32'h0, 32'(out_illegal));
        end
    end

    initial
    begin
        wait (trace_loaded);
        #((trace_q.size() * 2 + 20) * 8);
        $display("error: run timed out with %0d of %0d instructions checked",
                 checked, trace_q.size());
        $display("** FAIL **");
        $fatal(1);
    end

    initial
    begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        in_pc    = '0;
        rs1_data = '0;
        rs2_data = '0;
        load_trace();
        trace_loaded = 1'b1;

        repeat (9) @(posedge clk_in);
        @(negedge clk_in);
        compare_field("out_redirect_pc", `EXEC_RESET_PC, out_redirect_pc);
        @(posedge clk_in);
        rst_n <= 1'b1; // released after 10 cycles

        for (int i = 0; i < trace_q.size(); i++)
        begin
            if (i > 0 && i % 4 == 0)
            begin
                @(posedge clk_in);
                in_valid <= 1'b0; // idle slot
            end
            @(posedge clk_in);
            in_valid <= 1'b1;
            in_instr <= trace_q[i].instr;
            in_pc    <= trace_q[i].pc;
            rs1_data <= trace_q[i].rs1;
            rs2_data <= trace_q[i].rs2;
            pending_q.push_back(trace_q[i]);
        end
        @(posedge clk_in);
        in_valid <= 1'b0;

        while (checked < trace_q.size())
            @(posedge clk_in);
        repeat (2) @(posedge clk_in); // a few idle checks at the end

        $display("** PASS **");
        $finish;
    end

endmodule

//--- bench/exec_trace.txt
// instr pc rs1 rs2 | exp: rd_we rd_addr rd_data redirect redirect_pc overflow illegal
// rd_addr/rd_data only matter with rd_we, redirect_pc only with redirect
002081b3 00000100 00000005 00000007 1 03 0000000c 0 00000000 0 0
00208233 00000104 7fffffff 00000001 1 04 80000000 0 00000000 1 0
402082b3 00000108 80000000 00000001 1 05 7fffffff 0 00000000 1 0
40208333 0000010c 00000003 00000005 1 06 fffffffe 0 00000000 0 0
0020a3b3 00000110 ffffffff 00000001 1 07 00000001 0 00000000 0 0
0020b433 00000114 ffffffff 00000001 1 08 00000000 0 00000000 0 0
002094b3 00000118 00000001 00000024 1 09 00000010 0 00000000 0 0
0020d533 0000011c 80000000 00000021 1 0a 40000000 0 00000000 0 0
4020d5b3 00000120 80000000 00000024 1 0b f8000000 0 00000000 0 0
0020f633 00000124 ff00ff00 0f0f0f0f 1 0c 0f000f00 0 00000000 0 0
0020e6b3 00000128 ff00ff00 0f0f0f0f 1 0d ff0fff0f 0 00000000 0 0
0020c733 0000012c 7fffffff 00000001 1 0e 7ffffffe 0 00000000 0 0
00208033 00000130 00000001 00000002 0 00 00000000 0 00000000 0 0
fff08793 00000134 80000000 00000000 1 0f 7fffffff 0 00000000 1 0
fff0a813 00000138 fffffffe 00000000 1 10 00000001 0 00000000 0 0
4030d913 0000013c f0000000 00000000 1 12 fe000000 0 00000000 0 0
01f09993 00000140 00000003 00000000 1 13 80000000 0 00000000 0 0
abcdea37 00000144 00000000 00000000 1 14 abcde000 0 00000000 0 0
12345a97 00001000 00000000 00000000 1 15 12346000 0 00000000 0 0
80000b17 80000000 00000000 00000000 1 16 00000000 0 00000000 1 0
00208863 00000200 0000abcd 0000abcd 0 00 00000000 1 00000210 0 0
00209863 00000204 0000abcd 0000abcd 0 00 00000000 0 00000000 0 0
fe20cce3 00000300 ffffffff 00000001 0 00 00000000 1 000002f8 0 0
fe20dce3 00000304 ffffffff 00000001 0 00 00000000 0 00000000 0 0
fe20ece3 00000308 ffffffff 00000001 0 00 00000000 0 00000000 0 0
fe20fce3 00000400 ffffffff 00000001 0 00 00000000 1 000003f8 0 0
020000ef 00000500 00000000 00000000 1 01 00000504 1 00000520 0 0
007082e7 00000600 00001000 00000000 1 05 00000604 1 00001006 0 0
0000a183 00000700 00000000 00000000 0 00 00000000 0 00000000 0 1
022081b3 00000704 7fffffff 00000001 0 00 00000000 0 00000000 0 1
40109193 00000708 00000001 00000000 0 00 00000000 0 00000000 0 1

//--- tb.f
+incdir+common
common/rv_exec_pkg.sv
alu/alu.sv
hdl/inst_decoder.sv
hdl/result_unit.sv
hdl/exec_stage_top.sv
bench/exec_stage_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module exec_stage_tb -o exec_stage_sim \
    && ./obj_dir/exec_stage_sim | tee /dev/stderr | grep -F "** PASS **" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
